// ==== verilog/vi_consts.svh ====
// Widths, pipeline depth and RV32 encoding values for the core, included by every RTL file
`ifndef VI_CONSTS_SVH
`define VI_CONSTS_SVH

`define VI_XLEN        32
`define VI_REG_ADDR_W  5
`define VI_NUM_REGS    32
`define VI_MEM_ADDR_W  20
`define VI_MULT_STAGES 4
`define VI_RESET_PC    20'h00000

// Major opcodes
`define VI_OPC_OP      7'b0110011
`define VI_OPC_OP_IMM  7'b0010011
`define VI_OPC_STORE   7'b0100011

`define VI_F3_ADD      3'b000
`define VI_F3_SW       3'b010
`define VI_F3_OR       3'b110
`define VI_F3_AND      3'b111

`define VI_F7_BASE     7'b0000000
`define VI_F7_SUB      7'b0100000
`define VI_F7_MULDIV   7'b0000001

`endif

// ==== verilog/vi_isa_pkg.sv ====
// Instruction set types of the core, decoded operations and RV32 field slices, imported where used
`default_nettype none

package vi_isa_pkg;

	typedef logic [31:0] instr_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	typedef enum logic [2:0] {
		OP_NOP,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_ADDI,
		OP_MUL,
		OP_SW
	} op_e;

	// Ops whose result comes out of the ALU and goes to a register
	function automatic logic op_alu_write(op_e op);
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI};
	endfunction

endpackage

`default_nettype wire

// ==== verilog/vi_pipe_pkg.sv ====
// Datapath types shared by the pipeline stages, imported where used
`default_nettype none

`include "vi_consts.svh"

package vi_pipe_pkg;

	typedef logic [`VI_XLEN-1:0]       word_t;
	typedef logic [`VI_REG_ADDR_W-1:0] reg_addr_t;
	typedef logic [`VI_MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_unit.sv ====
// Instruction fetch over the four-phase memory port, feeding the one-entry decode buffer
`default_nettype none

`include "vi_consts.svh"

module fetch_unit (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic                   stall_i,
	input  logic                   mem_data_ready_i,
	input  vi_pipe_pkg::word_t     mem_data_i,
	output logic                   mem_read_o,
	output vi_pipe_pkg::mem_addr_t mem_read_addr_o,
	output logic                   instr_valid_o,
	output vi_isa_pkg::instr_t     instr_o
);
	import vi_isa_pkg::*;
	import vi_pipe_pkg::*;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_RELEASE
	} fetch_state_e;

	fetch_state_e state_q;
	mem_addr_t pc_q;
	logic buf_valid_q;
	instr_t buf_instr_q;
	logic consume;
	logic can_start;
	logic capture;

	assign consume = buf_valid_q && !stall_i;
	// Old acknowledge must be gone and the buffer free by the time data returns
	assign can_start = !mem_data_ready_i && (!buf_valid_q || consume);
	assign capture = (state_q == FETCH_REQ) && mem_data_ready_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= FETCH_IDLE;
			pc_q <= `VI_RESET_PC;
		end else begin
			case (state_q)
				FETCH_IDLE: begin
					if (can_start)
						state_q <= FETCH_REQ;
				end
				FETCH_REQ: begin
					if (capture) begin
						state_q <= FETCH_RELEASE;
						pc_q <= pc_q + mem_addr_t'(4);
					end
				end
				default: begin
					if (!mem_data_ready_i)
						state_q <= can_start ? FETCH_REQ : FETCH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i)
			buf_valid_q <= 1'b0;
		else if (capture)
			buf_valid_q <= 1'b1;
		else if (consume)
			buf_valid_q <= 1'b0;
	end

	always_ff @(posedge clk_i) begin
		if (capture)
			buf_instr_q <= mem_data_i;
	end

	assign mem_read_o = (state_q == FETCH_REQ);
	assign mem_read_addr_o = pc_q;
	assign instr_valid_o = buf_valid_q;
	assign instr_o = buf_instr_q;

endmodule

`default_nettype wire

// ==== verilog/decoder.sv ====
// Decode of the buffered instruction into operation, register indices and immediate
`default_nettype none

`include "vi_consts.svh"

module decoder (
	input  logic                   instr_valid_i,
	input  vi_isa_pkg::instr_t     instr_i,
	output vi_isa_pkg::op_e        op_o,
	output vi_pipe_pkg::reg_addr_t rs1_o,
	output vi_pipe_pkg::reg_addr_t rs2_o,
	output vi_pipe_pkg::reg_addr_t rd_o,
	output vi_pipe_pkg::word_t     imm_o
);
	import vi_isa_pkg::*;
	import vi_pipe_pkg::*;

	opcode_t opcode;
	funct3_t funct3;
	funct7_t funct7;
	reg_addr_t rd_field;
	op_e op;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];
	assign rd_field = instr_i[11:7];

	always_comb begin
		op = OP_NOP;
		case (opcode)
			`VI_OPC_OP: begin
				if (funct7 == `VI_F7_BASE && funct3 == `VI_F3_ADD)
					op = OP_ADD;
				else if (funct7 == `VI_F7_SUB && funct3 == `VI_F3_ADD)
					op = OP_SUB;
				else if (funct7 == `VI_F7_BASE && funct3 == `VI_F3_AND)
					op = OP_AND;
				else if (funct7 == `VI_F7_BASE && funct3 == `VI_F3_OR)
					op = OP_OR;
				else if (funct7 == `VI_F7_MULDIV && funct3 == `VI_F3_ADD)
					op = OP_MUL;
			end
			`VI_OPC_OP_IMM: begin
				if (funct3 == `VI_F3_ADD)
					op = OP_ADDI;
			end
			`VI_OPC_STORE: begin
				if (funct3 == `VI_F3_SW)
					op = OP_SW;
			end
			default: op = OP_NOP;
		endcase
		if (!instr_valid_i)
			op = OP_NOP;
		// Writes to x0 are dropped here so no later stage sees rd 0
		if ((op_alu_write(op) || op == OP_MUL) && rd_field == '0)
			op = OP_NOP;
	end

	assign op_o = op;
	// Unused sources read as x0 so they never match a hazard
	assign rs1_o = (op == OP_NOP) ? '0 : instr_i[19:15];
	assign rs2_o = (op == OP_NOP || op == OP_ADDI) ? '0 : instr_i[24:20];
	assign rd_o = (op == OP_NOP || op == OP_SW) ? '0 : rd_field;
	assign imm_o = (op == OP_SW) ?
		{{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]} :
		{{20{instr_i[31]}}, instr_i[31:20]};

endmodule

`default_nettype wire

// ==== verilog/int_registers.sv ====
// Integer register file, two combinational reads and one write at the clock edge
`default_nettype none

`include "vi_consts.svh"

module int_registers (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  vi_pipe_pkg::reg_addr_t rs1_i,
	input  vi_pipe_pkg::reg_addr_t rs2_i,
	input  logic                   wr_en_i,
	input  vi_pipe_pkg::reg_addr_t wr_addr_i,
	input  vi_pipe_pkg::word_t     wr_data_i,
	output vi_pipe_pkg::word_t     rs1_data_o,
	output vi_pipe_pkg::word_t     rs2_data_o
);
	import vi_pipe_pkg::*;

	word_t regs_q [`VI_NUM_REGS];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			for (int i = 0; i < `VI_NUM_REGS; i++)
				regs_q[i] <= '0;
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs_q[wr_addr_i] <= wr_data_i;
		end
	end

	assign rs1_data_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

`default_nettype wire

// ==== verilog/bypass_ctrl.sv ====
// Operand forwarding into decode and the decode stall for multiply hazards
`default_nettype none

`include "vi_consts.svh"

module bypass_ctrl (
	input  vi_isa_pkg::op_e                                 op_i,
	input  vi_pipe_pkg::reg_addr_t                          rs1_i,
	input  vi_pipe_pkg::reg_addr_t                          rs2_i,
	input  vi_pipe_pkg::word_t                              rs1_data_i,
	input  vi_pipe_pkg::word_t                              rs2_data_i,
	input  vi_isa_pkg::op_e                                 exe_op_i,
	input  vi_pipe_pkg::reg_addr_t                          exe_rd_i,
	input  vi_pipe_pkg::word_t                              exe_result_i,
	input  logic [`VI_MULT_STAGES-1:0]                      mult_valid_i,
	input  vi_pipe_pkg::reg_addr_t [`VI_MULT_STAGES-1:0]    mult_rd_i,
	input  logic                                            wb_en_i,
	input  vi_pipe_pkg::reg_addr_t                          wb_addr_i,
	input  vi_pipe_pkg::word_t                              wb_data_i,
	output vi_pipe_pkg::word_t                              op_a_o,
	output vi_pipe_pkg::word_t                              op_b_o,
	output logic                                            stall_o
);
	import vi_isa_pkg::*;
	import vi_pipe_pkg::*;

	logic exe_fwd;
	logic port_clash;

	assign exe_fwd = op_alu_write(exe_op_i);

	// Execute result wins over the writeback latch, which wins over the register file
	function automatic word_t forward(reg_addr_t src, word_t rf_data);
		if (src == '0)
			return rf_data;
		if (exe_fwd && exe_rd_i == src)
			return exe_result_i;
		if (wb_en_i && wb_addr_i == src)
			return wb_data_i;
		return rf_data;
	endfunction

	// Product for src not yet in the writeback latch
	function automatic logic mul_pending(reg_addr_t src);
		logic hit;
		hit = (exe_op_i == OP_MUL) && (exe_rd_i == src);
		for (int i = 0; i < `VI_MULT_STAGES; i++)
			hit = hit || (mult_valid_i[i] && mult_rd_i[i] == src);
		return hit && (src != '0);
	endfunction

	// Product that reaches the writeback latch together with this instruction
	assign port_clash = op_alu_write(op_i) && mult_valid_i[`VI_MULT_STAGES-2];

	always_comb begin
		op_a_o = forward(rs1_i, rs1_data_i);
		op_b_o = forward(rs2_i, rs2_data_i);
		stall_o = mul_pending(rs1_i) || mul_pending(rs2_i) || port_clash;
	end

endmodule

`default_nettype wire

// ==== verilog/exe_stage.sv ====
// Execute stage with ALU, store issue and the writeback latch shared by ALU and multiplier
`default_nettype none

`include "vi_consts.svh"

module exe_stage (
	input  logic                   clk_i,
	input  logic                   reset_i,
	input  logic                   stall_i,
	input  vi_isa_pkg::op_e        op_i,
	input  vi_pipe_pkg::reg_addr_t rd_i,
	input  vi_pipe_pkg::word_t     op_a_i,
	input  vi_pipe_pkg::word_t     op_b_i,
	input  vi_pipe_pkg::word_t     imm_i,
	input  logic                   mult_valid_i,
	input  vi_pipe_pkg::reg_addr_t mult_rd_i,
	input  vi_pipe_pkg::word_t     mult_result_i,
	output vi_isa_pkg::op_e        exe_op_o,
	output vi_pipe_pkg::reg_addr_t exe_rd_o,
	output vi_pipe_pkg::word_t     exe_result_o,
	output logic                   mult_start_o,
	output vi_pipe_pkg::word_t     mult_a_o,
	output vi_pipe_pkg::word_t     mult_b_o,
	output logic                   wb_en_o,
	output vi_pipe_pkg::reg_addr_t wb_addr_o,
	output vi_pipe_pkg::word_t     wb_data_o,
	output logic                   mem_write_enable_o,
	output vi_pipe_pkg::mem_addr_t mem_write_addr_o,
	output vi_pipe_pkg::word_t     mem_write_data_o
);
	import vi_isa_pkg::*;
	import vi_pipe_pkg::*;

	op_e op_q;
	reg_addr_t rd_q;
	word_t a_q;
	word_t b_q;
	word_t imm_q;
	word_t alu_result;

	always_ff @(posedge clk_i) begin
		if (reset_i || stall_i)
			op_q <= OP_NOP;
		else
			op_q <= op_i;
	end

	always_ff @(posedge clk_i) begin
		rd_q <= rd_i;
		a_q <= op_a_i;
		b_q <= op_b_i;
		imm_q <= imm_i;
	end

	always_comb begin
		case (op_q)
			OP_ADD:        alu_result = a_q + b_q;
			OP_SUB:        alu_result = a_q - b_q;
			OP_AND:        alu_result = a_q & b_q;
			OP_OR:         alu_result = a_q | b_q;
			OP_ADDI, OP_SW: alu_result = a_q + imm_q;
			default:       alu_result = '0;
		endcase
	end

	// Bypass keeps ALU writes away from cycles where a product arrives
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wb_en_o <= 1'b0;
			mem_write_enable_o <= 1'b0;
		end else begin
			wb_en_o <= mult_valid_i || op_alu_write(op_q);
			mem_write_enable_o <= (op_q == OP_SW);
		end
	end

	always_ff @(posedge clk_i) begin
		wb_addr_o <= mult_valid_i ? mult_rd_i : rd_q;
		wb_data_o <= mult_valid_i ? mult_result_i : alu_result;
		mem_write_addr_o <= alu_result[`VI_MEM_ADDR_W-1:0];
		mem_write_data_o <= b_q;
	end

	assign exe_op_o = op_q;
	assign exe_rd_o = rd_q;
	assign exe_result_o = alu_result;
	assign mult_start_o = (op_q == OP_MUL);
	assign mult_a_o = a_q;
	assign mult_b_o = b_q;

endmodule

`default_nettype wire

// ==== verilog/mult_pipe.sv ====
// Multiply path, product formed on entry and carried with its rd through the stage registers
`default_nettype none

`include "vi_consts.svh"

module mult_pipe (
	input  logic                                         clk_i,
	input  logic                                         reset_i,
	input  logic                                         start_i,
	input  vi_pipe_pkg::reg_addr_t                       rd_i,
	input  vi_pipe_pkg::word_t                           a_i,
	input  vi_pipe_pkg::word_t                           b_i,
	output logic [`VI_MULT_STAGES-1:0]                   valid_o,
	output vi_pipe_pkg::reg_addr_t [`VI_MULT_STAGES-1:0] rd_o,
	output vi_pipe_pkg::word_t                           result_o
);
	import vi_pipe_pkg::*;

	logic [`VI_MULT_STAGES-1:0] valid_q;
	reg_addr_t [`VI_MULT_STAGES-1:0] rd_q;
	word_t prod_q [`VI_MULT_STAGES];

	always_ff @(posedge clk_i) begin
		if (reset_i)
			valid_q <= '0;
		else
			valid_q <= {valid_q[`VI_MULT_STAGES-2:0], start_i};
	end

	// Low word of the product only
	always_ff @(posedge clk_i) begin
		rd_q[0] <= rd_i;
		prod_q[0] <= word_t'(a_i * b_i);
		for (int i = 1; i < `VI_MULT_STAGES; i++) begin
			rd_q[i] <= rd_q[i-1];
			prod_q[i] <= prod_q[i-1];
		end
	end

	assign valid_o = valid_q;
	assign rd_o = rd_q;
	assign result_o = prod_q[`VI_MULT_STAGES-1];

endmodule

`default_nettype wire

// ==== verilog/vi_core.sv ====
// Top of the integer pipeline, wires fetch, decode, execute, multiply and writeback together
`default_nettype none

`include "vi_consts.svh"

module vi_core (
	input  logic                   clk_i,
	input  logic                   reset_i,
	output logic                   mem_read_o,
	output vi_pipe_pkg::mem_addr_t mem_read_addr_o,
	input  logic                   mem_data_ready_i,
	input  vi_pipe_pkg::word_t     mem_data_i,
	output logic                   mem_write_enable_o,
	output vi_pipe_pkg::mem_addr_t mem_write_addr_o,
	output vi_pipe_pkg::word_t     mem_write_data_o
);
	import vi_isa_pkg::*;
	import vi_pipe_pkg::*;

	// Fetch to decode
	logic instr_valid;
	instr_t instr;

	// Decode
	op_e dec_op;
	reg_addr_t dec_rs1;
	reg_addr_t dec_rs2;
	reg_addr_t dec_rd;
	word_t dec_imm;
	word_t rs1_data;
	word_t rs2_data;
	word_t op_a;
	word_t op_b;
	logic stall;

	// Execute and writeback
	op_e exe_op;
	reg_addr_t exe_rd;
	word_t exe_result;
	logic wb_en;
	reg_addr_t wb_addr;
	word_t wb_data;

	// Multiply path
	logic mult_start;
	word_t mult_a;
	word_t mult_b;
	logic [`VI_MULT_STAGES-1:0] mult_valid;
	reg_addr_t [`VI_MULT_STAGES-1:0] mult_rd;
	word_t mult_result;

	fetch_unit fetch_unit (
		.clk_i            (clk_i),
		.reset_i          (reset_i),
		.stall_i          (stall),
		.mem_data_ready_i (mem_data_ready_i),
		.mem_data_i       (mem_data_i),
		.mem_read_o       (mem_read_o),
		.mem_read_addr_o  (mem_read_addr_o),
		.instr_valid_o    (instr_valid),
		.instr_o          (instr)
	);

	decoder decoder (
		.instr_valid_i (instr_valid),
		.instr_i       (instr),
		.op_o          (dec_op),
		.rs1_o         (dec_rs1),
		.rs2_o         (dec_rs2),
		.rd_o          (dec_rd),
		.imm_o         (dec_imm)
	);

	int_registers int_registers (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.rs1_i      (dec_rs1),
		.rs2_i      (dec_rs2),
		.wr_en_i    (wb_en),
		.wr_addr_i  (wb_addr),
		.wr_data_i  (wb_data),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	bypass_ctrl bypass_ctrl (
		.op_i         (dec_op),
		.rs1_i        (dec_rs1),
		.rs2_i        (dec_rs2),
		.rs1_data_i   (rs1_data),
		.rs2_data_i   (rs2_data),
		.exe_op_i     (exe_op),
		.exe_rd_i     (exe_rd),
		.exe_result_i (exe_result),
		.mult_valid_i (mult_valid),
		.mult_rd_i    (mult_rd),
		.wb_en_i      (wb_en),
		.wb_addr_i    (wb_addr),
		.wb_data_i    (wb_data),
		.op_a_o       (op_a),
		.op_b_o       (op_b),
		.stall_o      (stall)
	);

	exe_stage exe_stage (
		.clk_i              (clk_i),
		.reset_i            (reset_i),
		.stall_i            (stall),
		.op_i               (dec_op),
		.rd_i               (dec_rd),
		.op_a_i             (op_a),
		.op_b_i             (op_b),
		.imm_i              (dec_imm),
		.mult_valid_i       (mult_valid[`VI_MULT_STAGES-1]),
		.mult_rd_i          (mult_rd[`VI_MULT_STAGES-1]),
		.mult_result_i      (mult_result),
		.exe_op_o           (exe_op),
		.exe_rd_o           (exe_rd),
		.exe_result_o       (exe_result),
		.mult_start_o       (mult_start),
		.mult_a_o           (mult_a),
		.mult_b_o           (mult_b),
		.wb_en_o            (wb_en),
		.wb_addr_o          (wb_addr),
		.wb_data_o          (wb_data),
		.mem_write_enable_o (mem_write_enable_o),
		.mem_write_addr_o   (mem_write_addr_o),
		.mem_write_data_o   (mem_write_data_o)
	);

	mult_pipe mult_pipe (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.start_i  (mult_start),
		.rd_i     (exe_rd),
		.a_i      (mult_a),
		.b_i      (mult_b),
		.valid_o  (mult_valid),
		.rd_o     (mult_rd),
		.result_o (mult_result)
	);

endmodule

`default_nettype wire

// ==== bench/vi_core_props.sv ====
// Fetch handshake and reset-state assertions, bound to vi_core from this file
`default_nettype none

module vi_core_props (
	input logic                   clk_i,
	input logic                   reset_i,
	input logic                   read_i,
	input vi_pipe_pkg::mem_addr_t read_addr_i,
	input logic                   ready_i,
	input logic                   write_enable_i
);
	int fails;

	// A request waits for its acknowledge
	req_held: assert property (@(posedge clk_i) disable iff (reset_i)
		read_i && !ready_i |=> read_i)
		else begin
			fails++;
			$error("fetch request dropped before acknowledge");
		end

	addr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		read_i && !ready_i |=> $stable(read_addr_i))
		else begin
			fails++;
			$error("fetch address changed while the request was waiting");
		end

	// Old acknowledge gone before the next request starts
	no_early_req: assert property (@(posedge clk_i) disable iff (reset_i)
		$rose(read_i) |-> !$past(ready_i))
		else begin
			fails++;
			$error("new fetch request while acknowledge was still high");
		end

	reset_quiet: assert property (@(posedge clk_i)
		reset_i |=> !read_i && !write_enable_i)
		else begin
			fails++;
			$error("fetch request or store active after a reset cycle");
		end

endmodule

bind vi_core vi_core_props props0 (
	.clk_i          (clk_i),
	.reset_i        (reset_i),
	.read_i         (mem_read_o),
	.read_addr_i    (mem_read_addr_o),
	.ready_i        (mem_data_ready_i),
	.write_enable_i (mem_write_enable_o)
);

`default_nettype wire

// ==== bench/vi_core_tb.sv ====
// Testbench for vi_core, runs directed programs from a memory model and checks every store
`default_nettype none

`include "vi_consts.svh"

module vi_core_tb;
	import vi_pipe_pkg::*;

	logic clk;
	logic reset;
	logic mem_read;
	mem_addr_t mem_read_addr;
	logic mem_data_ready;
	word_t mem_data;
	logic mem_write_enable;
	mem_addr_t mem_write_addr;
	word_t mem_write_data;

	integer seed;
	int errors;
	bit random_latency;
	bit mem_busy;
	int mem_delay;

	word_t prog[$];
	mem_addr_t exp_addr[$];
	word_t exp_data[$];
	mem_addr_t got_addr[$];
	word_t got_data[$];

	vi_core dut0 (
		.clk_i              (clk),
		.reset_i            (reset),
		.mem_read_o         (mem_read),
		.mem_read_addr_o    (mem_read_addr),
		.mem_data_ready_i   (mem_data_ready),
		.mem_data_i         (mem_data),
		.mem_write_enable_o (mem_write_enable),
		.mem_write_addr_o   (mem_write_addr),
		.mem_write_data_o   (mem_write_data)
	);

	always #5 clk = ~clk;

	function automatic word_t r_type(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `VI_OPC_OP};
	endfunction

	function automatic word_t add_rr(int rd, int rs1, int rs2);
		return r_type(`VI_F7_BASE, rs2, rs1, `VI_F3_ADD, rd);
	endfunction

	function automatic word_t sub_rr(int rd, int rs1, int rs2);
		return r_type(`VI_F7_SUB, rs2, rs1, `VI_F3_ADD, rd);
	endfunction

	function automatic word_t and_rr(int rd, int rs1, int rs2);
		return r_type(`VI_F7_BASE, rs2, rs1, `VI_F3_AND, rd);
	endfunction

	function automatic word_t or_rr(int rd, int rs1, int rs2);
		return r_type(`VI_F7_BASE, rs2, rs1, `VI_F3_OR, rd);
	endfunction

	function automatic word_t mul_rr(int rd, int rs1, int rs2);
		return r_type(`VI_F7_MULDIV, rs2, rs1, `VI_F3_ADD, rd);
	endfunction

	function automatic word_t addi_ri(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], `VI_F3_ADD, rd[4:0], `VI_OPC_OP_IMM};
	endfunction

	function automatic word_t sw_ri(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], `VI_F3_SW, imm[4:0], `VI_OPC_STORE};
	endfunction

	// Past the program the memory answers with opcode 7f, which decodes to nothing
	function automatic word_t fetch_word(mem_addr_t addr);
		int idx;
		idx = int'(addr[`VI_MEM_ADDR_W-1:2]);
		if (idx < prog.size())
			return prog[idx];
		return {addr, 5'b00000, 7'h7f};
	endfunction

	// Memory side of the four-phase fetch port
	always @(posedge clk) begin
		#1;
		if (mem_data_ready) begin
			if (!mem_read)
				mem_data_ready = 1'b0;
		end else if (mem_read) begin
			if (!mem_busy) begin
				mem_busy = 1'b1;
				mem_delay = random_latency ? int'($unsigned($random(seed)) % 4) : 0;
			end
			if (mem_delay == 0) begin
				mem_data = fetch_word(mem_read_addr);
				mem_data_ready = 1'b1;
				mem_busy = 1'b0;
			end else begin
				mem_delay--;
			end
		end
	end

	always @(negedge clk) begin
		if (!reset && mem_write_enable === 1'b1) begin
			got_addr.push_back(mem_write_addr);
			got_data.push_back(mem_write_data);
		end
	end

	// Executes the program in order on an architectural register array
	task automatic reference_model();
		word_t regs [32];
		word_t w;
		word_t a;
		word_t b;
		word_t res;
		logic wr;
		for (int r = 0; r < 32; r++)
			regs[r] = '0;
		exp_addr.delete();
		exp_data.delete();
		foreach (prog[i]) begin
			w = prog[i];
			a = regs[w[19:15]];
			b = regs[w[24:20]];
			wr = 1'b1;
			res = '0;
			if (w[6:0] == `VI_OPC_OP && w[14:12] == `VI_F3_ADD && w[31:25] == `VI_F7_BASE)
				res = a + b;
			else if (w[6:0] == `VI_OPC_OP && w[14:12] == `VI_F3_ADD && w[31:25] == `VI_F7_SUB)
				res = a - b;
			else if (w[6:0] == `VI_OPC_OP && w[14:12] == `VI_F3_AND && w[31:25] == `VI_F7_BASE)
				res = a & b;
			else if (w[6:0] == `VI_OPC_OP && w[14:12] == `VI_F3_OR && w[31:25] == `VI_F7_BASE)
				res = a | b;
			else if (w[6:0] == `VI_OPC_OP && w[14:12] == `VI_F3_ADD && w[31:25] == `VI_F7_MULDIV)
				res = a * b;
			else if (w[6:0] == `VI_OPC_OP_IMM && w[14:12] == `VI_F3_ADD)
				res = a + {{20{w[31]}}, w[31:20]};
			else begin
				wr = 1'b0;
				if (w[6:0] == `VI_OPC_STORE && w[14:12] == `VI_F3_SW) begin
					res = a + {{20{w[31]}}, w[31:25], w[11:7]};
					exp_addr.push_back(res[`VI_MEM_ADDR_W-1:0]);
					exp_data.push_back(b);
				end
			end
			if (wr && w[11:7] != 5'd0)
				regs[w[11:7]] = res;
		end
	endtask

	task automatic apply_reset();
		int cycles;
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (3) begin
			@(posedge clk);
			#1;
			if (mem_read !== 1'b0) begin
				$display("ERROR t=%0t mem_read_o got %b expected 0", $time, mem_read);
				errors++;
			end
			if (mem_write_enable !== 1'b0) begin
				$display("ERROR t=%0t mem_write_enable_o got %b expected 0", $time,
					mem_write_enable);
				errors++;
			end
		end
		reset = 1'b0;
		cycles = 0;
		while (mem_read !== 1'b1 && cycles < 50) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (mem_read !== 1'b1) begin
			$display("No fetch request within 50 cycles after reset at %0t", $time);
			errors++;
		end else if (mem_read_addr !== `VI_RESET_PC) begin
			$display("ERROR t=%0t mem_read_addr_o got %h expected %h", $time, mem_read_addr,
				`VI_RESET_PC);
			errors++;
		end
	endtask

	task automatic compare_stores(input string name);
		int n;
		n = (got_addr.size() < exp_addr.size()) ? got_addr.size() : exp_addr.size();
		if (got_addr.size() != exp_addr.size()) begin
			$display("ERROR t=%0t %s: store count got %0d expected %0d", $time, name,
				got_addr.size(), exp_addr.size());
			errors++;
		end
		for (int i = 0; i < n; i++) begin
			if (got_addr[i] !== exp_addr[i]) begin
				$display("ERROR t=%0t %s: mem_write_addr_o of store %0d got %h expected %h",
					$time, name, i, got_addr[i], exp_addr[i]);
				errors++;
			end
			if (got_data[i] !== exp_data[i]) begin
				$display("ERROR t=%0t %s: mem_write_data_o of store %0d got %h expected %h",
					$time, name, i, got_data[i], exp_data[i]);
				errors++;
			end
		end
	endtask

	task automatic run_program(input string name);
		int cycles;
		mem_addr_t drain_addr;
		reference_model();
		apply_reset();
		got_addr.delete();
		got_data.delete();
		cycles = 0;
		while (got_addr.size() < exp_addr.size() && cycles < 2000) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (got_addr.size() < exp_addr.size()) begin
			$display("%s: timed out at %0t with %0d of %0d stores seen", name, $time,
				got_addr.size(), exp_addr.size());
			errors++;
		end
		// Let fetch run well past the program so any stray store would show up
		drain_addr = mem_addr_t'((prog.size() + 8) * 4);
		cycles = 0;
		while (mem_read_addr < drain_addr && cycles < 2000) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (mem_read_addr < drain_addr) begin
			$display("%s: fetch stopped before passing the program end at %0t", name, $time);
			errors++;
		end
		compare_stores(name);
	endtask

	task automatic load_alu_program();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 100));
		prog.push_back(addi_ri(2, 0, -7));
		prog.push_back(addi_ri(3, 0, 1445));
		prog.push_back(addi_ri(4, 0, 240));
		prog.push_back(add_rr(5, 1, 2));
		prog.push_back(sub_rr(6, 2, 3));
		prog.push_back(and_rr(7, 3, 4));
		prog.push_back(or_rr(8, 3, 4));
		prog.push_back(sw_ri(5, 0, 256));
		prog.push_back(sw_ri(6, 0, 260));
		prog.push_back(sw_ri(7, 0, 264));
		prog.push_back(sw_ri(8, 1, -4));
		prog.push_back(sw_ri(2, 2, 2000));
	endtask

	task automatic alu_ops_test();
		load_alu_program();
		run_program("alu ops");
	endtask

	// Each result is consumed by the very next instruction
	task automatic forwarding_test();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 5));
		prog.push_back(add_rr(2, 1, 1));
		prog.push_back(sub_rr(3, 2, 1));
		prog.push_back(add_rr(4, 3, 2));
		prog.push_back(or_rr(5, 4, 1));
		prog.push_back(addi_ri(5, 5, -3));
		prog.push_back(and_rr(6, 5, 4));
		prog.push_back(sw_ri(6, 5, 0));
		prog.push_back(sw_ri(5, 6, 4));
		prog.push_back(addi_ri(7, 6, 1));
		prog.push_back(sw_ri(7, 7, 32));
		run_program("forwarding");
	endtask

	task automatic multiply_test();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 13));
		prog.push_back(addi_ri(2, 0, -11));
		prog.push_back(mul_rr(3, 1, 2));
		prog.push_back(add_rr(4, 3, 1));
		prog.push_back(sw_ri(4, 0, 64));
		// Independent writes behind a MUL compete for the writeback latch
		prog.push_back(mul_rr(5, 1, 1));
		prog.push_back(addi_ri(6, 0, 1));
		prog.push_back(addi_ri(7, 0, 2));
		prog.push_back(addi_ri(8, 0, 3));
		prog.push_back(addi_ri(9, 0, 4));
		prog.push_back(addi_ri(10, 0, 5));
		prog.push_back(sw_ri(5, 0, 68));
		prog.push_back(sw_ri(10, 5, 0));
		prog.push_back(mul_rr(11, 3, 3));
		prog.push_back(mul_rr(12, 11, 11));
		prog.push_back(sw_ri(12, 0, 72));
		prog.push_back(addi_ri(13, 0, 2047));
		prog.push_back(mul_rr(14, 13, 13));
		prog.push_back(mul_rr(14, 14, 14));
		prog.push_back(sw_ri(14, 0, 76));
		prog.push_back(sw_ri(6, 0, 80));
		prog.push_back(sw_ri(7, 0, 84));
		prog.push_back(sw_ri(8, 0, 88));
		prog.push_back(sw_ri(9, 0, 92));
		// Zero latency lines the write of x7 up with the x5 product
		random_latency = 1'b0;
		run_program("multiply fixed latency");
		random_latency = 1'b1;
		run_program("multiply");
	endtask

	task automatic zero_reg_test();
		prog.delete();
		prog.push_back(addi_ri(1, 0, 77));
		prog.push_back(addi_ri(0, 0, 55));
		prog.push_back(add_rr(0, 1, 1));
		prog.push_back(mul_rr(0, 1, 1));
		prog.push_back(sw_ri(0, 0, 128));
		prog.push_back(add_rr(2, 0, 1));
		prog.push_back(sw_ri(2, 0, 132));
		// SLL, DIV, LW, SB and an all-ones word
		prog.push_back(32'hffffffff);
		prog.push_back(32'h001090b3);
		prog.push_back(32'h0210c0b3);
		prog.push_back(32'h0000a083);
		prog.push_back(32'h08100623);
		prog.push_back(sw_ri(1, 0, 136));
		prog.push_back(sw_ri(3, 0, 140));
		run_program("zero register and unknown encodings");
	endtask

	task automatic latency_test();
		random_latency = 1'b0;
		load_alu_program();
		run_program("fixed latency");
		random_latency = 1'b1;
		load_alu_program();
		run_program("random latency");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		mem_data_ready = 1'b0;
		mem_data = '0;
		seed = 27454;
		errors = 0;
		random_latency = 1'b1;
		mem_busy = 1'b0;
		mem_delay = 0;
		alu_ops_test();
		forwarding_test();
		multiply_test();
		zero_reg_test();
		latency_test();
		errors = errors + dut0.props0.fails;
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/vi_isa_pkg.sv
verilog/vi_pipe_pkg.sv
verilog/fetch_unit.sv
verilog/decoder.sv
verilog/int_registers.sv
verilog/bypass_ctrl.sv
verilog/exe_stage.sv
verilog/mult_pipe.sv
verilog/vi_core.sv
bench/vi_core_props.sv
bench/vi_core_tb.sv

// ==== Makefile ====
TOP = vi_core_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null

obj_dir/V$(TOP): src.f verilog/*.sv verilog/*.svh bench/*.sv
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
